// File: list.f
verilog/pool_data_pkg.sv
verilog/pool_reg_pkg.sv
verilog/pool_config_regs.sv
verilog/pool_row_pair.sv
verilog/pooling_data_shift_register.sv
verilog/pool_window_combine.sv
verilog/pooling_layer.sv
verification/pooling_layer_tb.sv

// File: Makefile
# Verilator build and run of the pooling stage testbench
# override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= pooling_layer_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(wildcard verilog/*.sv verification/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator status alone does not
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/pooling_layer_tb.sv
// testbench of the 2x2 pooling stage
// clock, reset, register setup and random pixel images with gaps
// reference model of window results, checked by concurrent assertions

module pooling_layer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import pool_data_pkg::*;
  import pool_reg_pkg::*;

  localparam int WAIT_LIMIT = 200;                  // cycles before a wait gives up
  localparam int EXP_DEPTH  = 512;                  // expected results kept
  localparam int MAX_WIDTH  = 2 * LINEBUFFER_DEPTH; // widest legal image

  logic                      clk_i = 1'b0;
  logic                      reset;
  logic [CONV_WIDTH-1:0]     pix_data;
  logic                      pix_valid;
  logic                      reg_write;
  logic                      reg_read;
  logic [REG_ADDR_WIDTH-1:0] reg_addr;
  logic [REG_DATA_WIDTH-1:0] reg_wdata;
  logic [POOL_WIDTH-1:0]     pool_data;
  logic                      pool_valid;
  logic [REG_DATA_WIDTH-1:0] reg_rdata;
  logic                      reg_rvalid;

  // reference model state
  logic signed [POOL_WIDTH-1:0] exp_mem [EXP_DEPTH]; // window results in raster order
  logic signed [POOL_WIDTH-1:0] exp_head;
  logic [REG_DATA_WIDTH-1:0]    exp_rdata;          // data due on the next rvalid
  logic                         window_accept;      // pixel on the bus closes a window
  logic signed [CONV_WIDTH-1:0] above_row [MAX_WIDTH];
  logic signed [CONV_WIDTH-1:0] cur_row [MAX_WIDTH];
  int                           wr_ptr = 0;
  int                           rd_ptr = 0;
  int                           count_base = 0;     // wr_ptr when enable last rose
  logic [31:0]                  rng_state = 32'hb6a0_f239;
  string                        test_name = "reset";

  always #20 clk_i = ~clk_i; // 40 ns period

  pooling_layer uut (
    .clk_i      (clk_i),
    .reset      (reset),
    .pix_data   (pix_data),
    .pix_valid  (pix_valid),
    .reg_write  (reg_write),
    .reg_read   (reg_read),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .pool_data  (pool_data),
    .pool_valid (pool_valid),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid)
  );

  assign exp_head = exp_mem[rd_ptr % EXP_DEPTH];

  always @(posedge clk_i) begin
    if (!reset && pool_valid) rd_ptr <= rd_ptr + 1; // one window consumed
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int max_of(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  task automatic value_error(input string name, input int expected, input int actual);
    $display("ERR %s expected %0d actual %0d", name, expected, actual);
    $display("SIMULATION FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic abort_run(input string what);
    $display("%s (test %s)", what, test_name);
    $display("SIMULATION FAILED");
    $fatal(1, "check failed");
  endtask

  // outputs low on the cycle after any reset edge
  reset_quiet: assert property (@(posedge clk_i) reset |=> (!pool_valid && !reg_rvalid))
    else abort_run("pool_valid or reg_rvalid high after a reset cycle");

  window_value: assert property (@(posedge clk_i) disable iff (reset)
    pool_valid |-> (rd_ptr < wr_ptr && $signed(pool_data) == exp_head))
    else value_error(test_name, $sampled(exp_head), $signed($sampled(pool_data)));

  window_timing: assert property (@(posedge clk_i) disable iff (reset)
    window_accept |-> ##2 pool_valid)
    else abort_run("no pool_valid two cycles after the closing pixel of a window");

  window_origin: assert property (@(posedge clk_i) disable iff (reset)
    pool_valid |-> $past(window_accept, 2))
    else abort_run("pool_valid without a closing window pixel two cycles before");

  read_latency: assert property (@(posedge clk_i) disable iff (reset) reg_read |=> reg_rvalid)
    else abort_run("reg_rvalid missing one cycle after reg_read");

  read_origin: assert property (@(posedge clk_i) disable iff (reset)
    reg_rvalid |-> $past(reg_read))
    else abort_run("reg_rvalid without a reg_read one cycle before");

  read_value: assert property (@(posedge clk_i) disable iff (reset)
    reg_rvalid |-> reg_rdata == exp_rdata)
    else value_error(test_name, $sampled(exp_rdata), $sampled(reg_rdata));

  task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                           input logic [REG_DATA_WIDTH-1:0] data);
    reg_write <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk_i); // write taken here
    reg_write <= 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                          input logic [REG_DATA_WIDTH-1:0] expected);
    int n;
    bit got;
    got = 1'b0;
    reg_read  <= 1'b1;
    reg_addr  <= addr;
    exp_rdata <= expected;
    @(posedge clk_i);
    reg_read <= 1'b0;
    for (n = 0; n < WAIT_LIMIT && !got; n++) begin
      @(negedge clk_i);
      got = reg_rvalid;
    end
    if (!got) abort_run("timeout waiting for reg_rvalid");
    @(posedge clk_i); // data compared on this edge
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (rd_ptr != wr_ptr && n < WAIT_LIMIT);
    if (rd_ptr != wr_ptr) abort_run("timeout waiting for pooled results");
    @(posedge clk_i);
  endtask

  // raster pixels from row 0 col 0, model only tracks them while enabled
  task automatic feed_pixels(input int width, input int npix, input bit avg, input bit model);
    int i;
    int k;
    int r;
    int c;
    int gap;
    int sum;
    logic signed [CONV_WIDTH-1:0] pix;
    for (i = 0; i < npix; i++) begin
      r = i / width;
      c = i % width;
      rng_state = xorshift32(rng_state);
      gap = rng_state[31] ? 0 : int'(rng_state[30:29]); // half the pixels back to back
      pix = rng_state[15:0];
      for (k = 0; k < gap; k++) begin
        pix_valid     <= 1'b0;
        window_accept <= 1'b0;
        @(posedge clk_i);
      end
      pix_data      <= pix;
      pix_valid     <= 1'b1;
      window_accept <= 1'b0;
      if (model && r % 2 == 1 && c % 2 == 1) begin // odd pixel of a second row
        if (avg) begin
          sum = int'(above_row[c-1]) + int'(above_row[c]) + int'(cur_row[c-1]) + int'(pix);
          exp_mem[wr_ptr % EXP_DEPTH] = sum >>> 2; // floor of sum / 4
        end else begin
          exp_mem[wr_ptr % EXP_DEPTH] = max_of(max_of(above_row[c-1], above_row[c]),
                                               max_of(cur_row[c-1], pix));
        end
        wr_ptr++;
        window_accept <= 1'b1;
      end
      cur_row[c] = pix;
      if (c == width - 1) above_row = cur_row; // row done
      @(posedge clk_i);
    end
    pix_valid     <= 1'b0;
    window_accept <= 1'b0;
  endtask

  task automatic enable_pool(input bit avg);
    logic [REG_DATA_WIDTH-1:0] ctrl;
    ctrl = '0;
    ctrl[CTRL_ENABLE_BIT] = 1'b1;
    ctrl[CTRL_MODE_BIT]   = avg;
    write_reg(ADDR_CTRL, ctrl);
    read_reg(ADDR_CTRL, ctrl);
    count_base = wr_ptr; // counter restarts with enable
  endtask

  task automatic disable_pool(input bit avg);
    logic [REG_DATA_WIDTH-1:0] ctrl;
    ctrl = '0;
    ctrl[CTRL_MODE_BIT] = avg;
    write_reg(ADDR_CTRL, ctrl);
    @(posedge clk_i);         // counter clears one edge after enable drops
    read_reg(ADDR_COUNT, '0);
  endtask

  task automatic pool_image(input string name, input int width, input int rows, input bit avg);
    test_name = name;
    write_reg(ADDR_WIDTH, width);
    read_reg(ADDR_WIDTH, width);
    enable_pool(avg);
    feed_pixels(width, width * rows, avg, 1'b1);
    wait_drained();
    read_reg(ADDR_COUNT, wr_ptr - count_base);
    disable_pool(avg);
  endtask

  initial begin
    reset         = 1'b1;
    pix_data      = '0;
    pix_valid     = 1'b0;
    reg_write     = 1'b0;
    reg_read      = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    exp_rdata     = '0;
    window_accept = 1'b0;
    repeat (10) @(posedge clk_i);
    reset <= 1'b0;

    read_reg(ADDR_CTRL, '0);         // disabled, max mode
    read_reg(ADDR_WIDTH, WIDTH_RESET);
    read_reg(ADDR_COUNT, '0);

    pool_image("max_w8", 8, 4, MODE_MAX);
    pool_image("avg_w16", 16, 4, MODE_AVG);
    pool_image("avg_full_buffer", MAX_WIDTH, 4, MODE_AVG);

    // stop inside a second row, idle pixels while off, then restart from row 0
    test_name = "restart";
    write_reg(ADDR_WIDTH, 8);
    enable_pool(MODE_MAX);
    feed_pixels(8, 11, MODE_MAX, 1'b1);
    wait_drained();
    read_reg(ADDR_COUNT, wr_ptr - count_base);
    disable_pool(MODE_MAX);
    feed_pixels(8, 12, MODE_MAX, 1'b0);
    enable_pool(MODE_MAX);
    feed_pixels(8, 32, MODE_MAX, 1'b1);
    wait_drained();
    read_reg(ADDR_COUNT, wr_ptr - count_base);
    disable_pool(MODE_MAX);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verilog/pooling_layer.sv
// top level of the 2x2 pooling stage
// register block beside the datapath
// row/pair tracking, line buffer and window combine in a chain

module pooling_layer (
  input  logic                                    clk_i,
  input  logic                                    reset,
  input  logic [pool_data_pkg::CONV_WIDTH-1:0]    pix_data,
  input  logic                                    pix_valid,
  input  logic                                    reg_write,
  input  logic                                    reg_read,
  input  logic [pool_reg_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [pool_reg_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
  output logic [pool_data_pkg::POOL_WIDTH-1:0]    pool_data,
  output logic                                    pool_valid,
  output logic [pool_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata,
  output logic                                    reg_rvalid
);

  logic                                 enable;
  logic                                 mode;
  logic [15:0]                          half_image_width; // pairs per row
  logic [pool_data_pkg::PAIR_WIDTH-1:0] pair_data;
  logic                                 pair_write;
  logic                                 second_row;
  logic [pool_data_pkg::PAIR_WIDTH-1:0] current_data;     // pair one row up

  pool_config_regs u_regs (
    .clk_i            (clk_i),
    .reset            (reset),
    .reg_write        (reg_write),
    .reg_read         (reg_read),
    .reg_addr         (reg_addr),
    .reg_wdata        (reg_wdata),
    .pool_valid       (pool_valid),
    .reg_rdata        (reg_rdata),
    .reg_rvalid       (reg_rvalid),
    .enable           (enable),
    .mode             (mode),
    .half_image_width (half_image_width)
  );

  pool_row_pair u_row_pair (
    .clk_i            (clk_i),
    .reset            (reset),
    .enable           (enable),
    .mode             (mode),
    .half_image_width (half_image_width),
    .pix_data         (pix_data),
    .pix_valid        (pix_valid),
    .pair_data        (pair_data),
    .pair_write       (pair_write),
    .second_row       (second_row)
  );

  // every pair is pushed, first and second row alike
  pooling_data_shift_register #(
    .LINEBUFFER_WIDTH (pool_data_pkg::LINEBUFFER_DEPTH),
    .CONV_WIDTH       (pool_data_pkg::PAIR_WIDTH)
  ) u_line_buffer (
    .clk_i            (clk_i),
    .reset            (reset),
    .data             (pair_data),
    .write            (pair_write),
    .half_image_width (half_image_width),
    .current_data     (current_data)
  );

  pool_window_combine u_combine (
    .clk_i        (clk_i),
    .reset        (reset),
    .mode         (mode),
    .pair_data    (pair_data),
    .pair_write   (pair_write),
    .second_row   (second_row),
    .current_data (current_data),
    .pool_data    (pool_data),
    .pool_valid   (pool_valid)
  );

endmodule

// File: verilog/pool_window_combine.sv
// vertical combining of a second-row pair with the pair above it
// max of the two, or floor average of the four pixel sum
// registered result with a one cycle valid strobe

module pool_window_combine (
  input  logic                                 clk_i,
  input  logic                                 reset,
  input  logic                                 mode,
  input  logic [pool_data_pkg::PAIR_WIDTH-1:0] pair_data,
  input  logic                                 pair_write,
  input  logic                                 second_row,
  input  logic [pool_data_pkg::PAIR_WIDTH-1:0] current_data,
  output logic [pool_data_pkg::POOL_WIDTH-1:0] pool_data,
  output logic                                 pool_valid
);

  import pool_data_pkg::*;

  logic                         window_done; // bottom pair of a window arrives
  logic signed [PAIR_WIDTH-1:0] below;       // pair from this row
  logic signed [PAIR_WIDTH-1:0] above;       // pair from the line buffer
  logic signed [PAIR_WIDTH-1:0] window_max;
  logic signed [SUM_WIDTH-1:0]  window_sum;  // all four pixels, no overflow
  logic signed [SUM_WIDTH-1:0]  window_avg;

  assign window_done = pair_write && second_row;

  assign below = pair_data;
  assign above = current_data;

  assign window_max = (below > above) ? below : above;
  assign window_sum = below + above;   // sign extended to SUM_WIDTH
  assign window_avg = window_sum >>> 2; // floor divide by 4

  always_ff @(posedge clk_i) begin
    if (reset) begin
      pool_valid <= 1'b0;
    end else begin
      pool_valid <= window_done;
    end
  end

  // both results fit the pixel width, upper bits are sign copies
  always_ff @(posedge clk_i) begin
    if (window_done) begin
      if (mode == MODE_AVG) begin
        pool_data <= window_avg[POOL_WIDTH-1:0];
      end else begin
        pool_data <= window_max[POOL_WIDTH-1:0];
      end
    end
  end

  // pairs take two pixels each, so results can never be back to back
  valid_single_cycle: assert property (
    @(posedge clk_i) disable iff (reset)
    pool_valid |=> !pool_valid
  );

endmodule

// File: verilog/pooling_data_shift_register.sv
// line buffer of pair results for one image row
// shift chain advancing on each write
// combinational tap at half_image_width-1 holding the pair one row above

module pooling_data_shift_register #(
  parameter int LINEBUFFER_WIDTH = 64,
  parameter int CONV_WIDTH       = 17
) (
  input  logic                  clk_i,
  input  logic                  reset,
  input  logic [CONV_WIDTH-1:0] data,
  input  logic                  write,
  input  logic [15:0]           half_image_width,
  output logic [CONV_WIDTH-1:0] current_data
);

  localparam int TAP_WIDTH = $clog2(LINEBUFFER_WIDTH);

  logic [LINEBUFFER_WIDTH-1:0][CONV_WIDTH-1:0] line_q; // entry 0 is the newest
  logic [15:0]                                 tap_full;
  logic [TAP_WIDTH-1:0]                        tap_idx;

  // each write pushes the chain up by one entry
  always_ff @(posedge clk_i) begin
    if (write) begin
      line_q <= {line_q[LINEBUFFER_WIDTH-2:0], data};
    end
  end

  // after half_image_width writes the partner pair sits at this entry
  assign tap_full = half_image_width - 16'd1;
  assign tap_idx  = tap_full[TAP_WIDTH-1:0]; // low bits address every entry

  always_comb begin
    current_data = line_q[tap_idx];
  end

  // a row longer than the buffer would read a wrapped, stale entry
  tap_in_range: assert property (
    @(posedge clk_i) disable iff (reset)
    write |-> (half_image_width >= 16'd1 && half_image_width <= LINEBUFFER_WIDTH)
  );

endmodule

// File: verilog/pool_row_pair.sv
// column and row tracking of the pixel stream
// horizontal combining of each even/odd pixel pair
// one registered pair result per odd column, tagged with the row parity

module pool_row_pair (
  input  logic                                  clk_i,
  input  logic                                  reset,
  input  logic                                  enable,
  input  logic                                  mode,
  input  logic [15:0]                           half_image_width,
  input  logic [pool_data_pkg::CONV_WIDTH-1:0]  pix_data,
  input  logic                                  pix_valid,
  output logic [pool_data_pkg::PAIR_WIDTH-1:0]  pair_data,
  output logic                                  pair_write,
  output logic                                  second_row
);

  import pool_data_pkg::*;

  logic                          accept;   // pixel taken this edge
  logic                          col_odd;  // next pixel is an odd column
  logic [15:0]                   pair_idx; // pair index within the row
  logic                          row_q;    // 1 in the second row of a window
  logic signed [CONV_WIDTH-1:0]  even_pix; // held left pixel of the pair
  logic signed [PAIR_WIDTH-1:0]  ext_even;
  logic signed [PAIR_WIDTH-1:0]  ext_odd;
  logic signed [PAIR_WIDTH-1:0]  pair_next;

  assign accept = pix_valid && enable;

  // sign extension to the pair width
  assign ext_even = even_pix;
  assign ext_odd  = $signed(pix_data);

  // sum in avg mode, larger pixel in max mode
  assign pair_next = (mode == MODE_AVG) ? (ext_even + ext_odd) :
                     (ext_odd > ext_even) ? ext_odd : ext_even;

  // position counters, parked at row 0 col 0 while disabled
  always_ff @(posedge clk_i) begin
    if (reset || !enable) begin
      col_odd  <= 1'b0;
      pair_idx <= '0;
      row_q    <= 1'b0;
    end else if (accept) begin
      col_odd <= !col_odd;
      if (col_odd) begin
        if (pair_idx == half_image_width - 16'd1) begin
          pair_idx <= '0;     // end of row
          row_q    <= !row_q; // flip window row
        end else begin
          pair_idx <= pair_idx + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !col_odd) even_pix <= $signed(pix_data);
  end

  // pair strobe and its row tag
  always_ff @(posedge clk_i) begin
    if (reset) begin
      pair_write <= 1'b0;
      second_row <= 1'b0;
    end else begin
      pair_write <= accept && col_odd;
      if (accept && col_odd) second_row <= row_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && col_odd) pair_data <= pair_next;
  end

endmodule

// File: verilog/pool_config_regs.sv
// register block of the pooling stage
// control (enable, mode) and image width registers
// counter of pooled results since enable went high
// registered read port with data one cycle after the read strobe

module pool_config_regs (
  input  logic                                    clk_i,
  input  logic                                    reset,
  input  logic                                    reg_write,
  input  logic                                    reg_read,
  input  logic [pool_reg_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [pool_reg_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
  input  logic                                    pool_valid,
  output logic [pool_reg_pkg::REG_DATA_WIDTH-1:0] reg_rdata,
  output logic                                    reg_rvalid,
  output logic                                    enable,
  output logic                                    mode,
  output logic [15:0]                             half_image_width
);

  import pool_reg_pkg::*;
  import pool_data_pkg::*;

  logic [REG_DATA_WIDTH-1:0] width_q;   // image width in pixels
  logic [COUNT_WIDTH-1:0]    count_q;   // pooled results produced
  logic [REG_DATA_WIDTH-1:0] rdata_next;

  // control and width registers
  always_ff @(posedge clk_i) begin
    if (reset) begin
      enable  <= CTRL_RESET[CTRL_ENABLE_BIT];
      mode    <= CTRL_RESET[CTRL_MODE_BIT];
      width_q <= WIDTH_RESET;
    end else if (reg_write) begin
      case (reg_addr)
        ADDR_CTRL: begin
          enable <= reg_wdata[CTRL_ENABLE_BIT];
          mode   <= reg_wdata[CTRL_MODE_BIT];
        end
        ADDR_WIDTH: width_q <= reg_wdata;
        default: ; // writes to the read only COUNT are dropped
      endcase
    end
  end

  // even width makes the pair count a plain shift
  assign half_image_width = {1'b0, width_q[15:1]};

  // result counter held at zero while the stage is disabled
  always_ff @(posedge clk_i) begin
    if (reset || !enable) begin
      count_q <= '0;
    end else if (pool_valid) begin
      count_q <= count_q + 1'b1;
    end
  end

  // read mux
  always_comb begin
    rdata_next = '0;
    case (reg_addr)
      ADDR_CTRL: begin
        rdata_next[CTRL_ENABLE_BIT] = enable;
        rdata_next[CTRL_MODE_BIT]   = mode;
      end
      ADDR_WIDTH: rdata_next = width_q;
      ADDR_COUNT: rdata_next = count_q;
      default:    rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_read;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_read) reg_rdata <= rdata_next; // held until the next read
  end

  // a width the line buffer cannot hold would break the tap alignment downstream
  width_write_legal: assert property (
    @(posedge clk_i) disable iff (reset)
    (reg_write && reg_addr == ADDR_WIDTH) |->
      (reg_wdata[0] == 1'b0 && reg_wdata != '0 && reg_wdata <= 2 * LINEBUFFER_DEPTH)
  );

endmodule

// File: verilog/pool_reg_pkg.sv
// register map of the pooling stage
// addresses, control bit positions, field widths and reset values

package pool_reg_pkg;

  localparam int REG_ADDR_WIDTH = 2;
  localparam int REG_DATA_WIDTH = 16;

  // addresses
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL  = 2'd0; // enable, mode
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_WIDTH = 2'd1; // image width in pixels
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_COUNT = 2'd2; // read only result count

  // bit positions in CTRL
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_MODE_BIT   = 1;

  // result counter spans the whole data word
  localparam int COUNT_WIDTH = REG_DATA_WIDTH;

  // reset values
  localparam logic [REG_DATA_WIDTH-1:0] CTRL_RESET  = '0;    // disabled, max mode
  localparam logic [REG_DATA_WIDTH-1:0] WIDTH_RESET = 16'd8; // 8 pixel rows

endpackage

// File: verilog/pool_data_pkg.sv
// datapath constants for the 2x2 pooling stage
// pixel, pair and pooled result widths
// line buffer depth and the mode encoding

package pool_data_pkg;

  // one signed convolution result per pixel
  localparam int CONV_WIDTH = 16;

  // horizontal pair result, one extra bit so the sum of two pixels fits
  localparam int PAIR_WIDTH = CONV_WIDTH + 1;

  // sum of two pair results, i.e. all four pixels of a window
  localparam int SUM_WIDTH = PAIR_WIDTH + 1;

  // pooled output, max or floor average of four pixels fits back in a pixel
  localparam int POOL_WIDTH = CONV_WIDTH;

  // pair results held for one row, image width up to 2*depth pixels
  localparam int LINEBUFFER_DEPTH = 64;

  // mode field, 1 bit
  localparam logic MODE_MAX = 1'b0; // max of the four pixels
  localparam logic MODE_AVG = 1'b1; // sum >>> 2

endpackage
